/* design/sec_cache_ctrl.sv */
/*
 * Cache controller FSM. Runs the security check, then either the cached path
 * (lookup, refill, write-through) or the memory bypass, and holds the response.
 */

`timescale 1ns/10ps

module sec_cache_ctrl (
	input  logic clk,
	input  logic reset,

	input  logic procreq_val,
	output logic procreq_rdy,
	output logic procresp_val,
	input  logic procresp_rdy,

	output logic memreq_val,
	output logic memreq_type,
	input  logic memreq_rdy,
	input  logic memresp_val,
	output logic memresp_rdy,

	input  logic cacheable,
	input  logic is_write,
	input  logic hit,

	output logic req_load,
	output logic resp_load,
	output logic resp_sel,
	output logic fill_en,
	output logic word_wr_en
);

	import sec_cache_pkg::*;

	logic [3:0] state;
	logic [3:0] state_next;

	// ------------------------------------------------------------------------
	// State register
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// ------------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (procreq_val)
					state_next = ST_SEC_CHECK;
			end
			ST_SEC_CHECK: begin
				// Policy decides cached or bypass
				if (cacheable)
					state_next = ST_LOOKUP;
				else
					state_next = ST_BYPASS_REQ;
			end
			ST_LOOKUP: begin
				if (is_write)
					state_next = ST_WRITE_REQ;
				else if (hit)
					state_next = ST_RESP;
				else
					state_next = ST_REFILL_REQ;
			end
			ST_BYPASS_REQ: begin
				if (memreq_rdy)
					state_next = ST_BYPASS_WAIT;
			end
			ST_BYPASS_WAIT: begin
				if (memresp_val)
					state_next = ST_RESP;
			end
			ST_REFILL_REQ: begin
				if (memreq_rdy)
					state_next = ST_REFILL_WAIT;
			end
			ST_REFILL_WAIT: begin
				if (memresp_val)
					state_next = ST_RESP;
			end
			ST_WRITE_REQ: begin
				if (memreq_rdy)
					state_next = ST_WRITE_WAIT;
			end
			ST_WRITE_WAIT: begin
				if (memresp_val)
					state_next = ST_RESP;
			end
			ST_RESP: begin
				if (procresp_rdy)
					state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// Outputs, decoded from the state alone except for the strobes
	// ------------------------------------------------------------------------

	always_comb begin
		procreq_rdy  = (state == ST_IDLE);
		procresp_val = (state == ST_RESP);
		memreq_val   = (state == ST_BYPASS_REQ) || (state == ST_REFILL_REQ) ||
			(state == ST_WRITE_REQ);
		memresp_rdy  = (state == ST_BYPASS_WAIT) || (state == ST_REFILL_WAIT) ||
			(state == ST_WRITE_WAIT);

		// Refill always reads, the other paths pass the request type on
		if (state == ST_REFILL_REQ)
			memreq_type = REQ_READ;
		else
			memreq_type = is_write;

		req_load   = (state == ST_IDLE) && procreq_val;

		// Memory line word on the wait states, store word on a lookup hit
		resp_sel   = (state == ST_BYPASS_WAIT) || (state == ST_REFILL_WAIT);
		resp_load  = ((state == ST_LOOKUP) && !is_write && hit) ||
			(resp_sel && memresp_val);

		fill_en    = (state == ST_REFILL_WAIT) && memresp_val;
		word_wr_en = (state == ST_LOOKUP) && is_write && hit;
	end

endmodule

/* design/sec_cache_datapath.sv */
/*
 * Request and response registers, the domain policy compare and the
 * extraction of the requested word from a memory line.
 */

`timescale 1ns/10ps

module sec_cache_datapath (
	input  logic                                clk,

	// Strobes from the controller
	input  logic                                req_load,
	input  logic                                resp_load,
	input  logic                                resp_sel,

	input  logic                                high_only,

	input  logic                                procreq_type,
	input  logic [sec_cache_pkg::ADDR_BITS-1:0] procreq_addr,
	input  logic [sec_cache_pkg::WORD_BITS-1:0] procreq_data,
	input  logic                                procreq_domain,

	input  logic [sec_cache_pkg::WORD_BITS-1:0] store_word,
	input  sec_cache_pkg::line_u                memresp_data,

	output logic                                is_write,
	output logic                                cacheable,
	output logic [sec_cache_pkg::ADDR_BITS-1:0] req_addr,
	output logic [sec_cache_pkg::WORD_BITS-1:0] req_data,
	output logic [sec_cache_pkg::WORD_BITS-1:0] procresp_data
);

	import sec_cache_pkg::*;

	logic                   req_type;
	logic                   req_domain;
	logic [OFFSET_BITS-1:0] req_offset;
	logic [WORD_BITS-1:0]   mem_word;
	logic [WORD_BITS-1:0]   resp_word;

	// ------------------------------------------------------------------------
	// Request registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (req_load) begin
			req_type   <= procreq_type;
			req_addr   <= procreq_addr;
			req_data   <= procreq_data;
			req_domain <= procreq_domain;
		end
	end

	assign is_write = (req_type == REQ_WRITE);

	// High requests always pass, low ones only when the policy allows both
	assign cacheable = (req_domain >= high_only);

	// ------------------------------------------------------------------------
	// Response word
	// ------------------------------------------------------------------------

	assign req_offset = req_addr[BYTE_BITS +: OFFSET_BITS];
	assign mem_word   = memresp_data.words[req_offset];

	assign resp_word = resp_sel ? mem_word : store_word;

	always_ff @(posedge clk) begin
		if (resp_load) begin
			procresp_data <= resp_word;
		end
	end

endmodule

/* design/sec_cache_pkg.sv */
/*
 * Shared sizes, address fields, request and state codes for the secure cache.
 * Modules pull these in with a wildcard import in the module body.
 */

package sec_cache_pkg;

	// ------------------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------------------

	localparam int ADDR_BITS   = 32;
	localparam int WORD_BITS   = 32;
	localparam int LINE_WORDS  = 4;
	localparam int LINE_BITS   = LINE_WORDS * WORD_BITS;
	localparam int NUM_LINES   = 16;

	// Address layout is tag | index | offset | byte
	localparam int BYTE_BITS   = 2;
	localparam int OFFSET_BITS = 2;
	localparam int INDEX_BITS  = 4;
	localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

	// ------------------------------------------------------------------------
	// Codes
	// ------------------------------------------------------------------------

	localparam logic REQ_READ    = 1'b0;
	localparam logic REQ_WRITE   = 1'b1;

	localparam logic DOMAIN_LOW  = 1'b0;
	localparam logic DOMAIN_HIGH = 1'b1;

	// Controller states
	localparam logic [3:0] ST_IDLE        = 4'd0;
	localparam logic [3:0] ST_SEC_CHECK   = 4'd1;
	localparam logic [3:0] ST_LOOKUP      = 4'd2;
	localparam logic [3:0] ST_BYPASS_REQ  = 4'd3;
	localparam logic [3:0] ST_BYPASS_WAIT = 4'd4;
	localparam logic [3:0] ST_REFILL_REQ  = 4'd5;
	localparam logic [3:0] ST_REFILL_WAIT = 4'd6;
	localparam logic [3:0] ST_WRITE_REQ   = 4'd7;
	localparam logic [3:0] ST_WRITE_WAIT  = 4'd8;
	localparam logic [3:0] ST_RESP        = 4'd9;

	// A cache line, seen whole on the memory side and per word on the processor side
	typedef union packed {
		logic [LINE_BITS-1:0]                  flat;
		logic [LINE_WORDS-1:0][WORD_BITS-1:0] words;
	} line_u;

endpackage

/* design/sec_cache_store.sv */
/*
 * Direct-mapped line store with valid bits and tags. Gives the hit flag and
 * stored word for the registered address, takes line fills and word writes.
 */

`timescale 1ns/10ps

module sec_cache_store (
	input  logic                                clk,
	input  logic                                reset,

	input  logic [sec_cache_pkg::ADDR_BITS-1:0] req_addr,
	input  logic [sec_cache_pkg::WORD_BITS-1:0] req_data,

	input  logic                                fill_en,
	input  logic                                word_wr_en,
	input  sec_cache_pkg::line_u                memresp_data,

	output logic                                hit,
	output logic [sec_cache_pkg::WORD_BITS-1:0] store_word
);

	import sec_cache_pkg::*;

	logic [NUM_LINES-1:0] valid;
	logic [TAG_BITS-1:0]  tags [NUM_LINES];
	line_u                lines [NUM_LINES];

	logic [TAG_BITS-1:0]    addr_tag;
	logic [INDEX_BITS-1:0]  addr_index;
	logic [OFFSET_BITS-1:0] addr_offset;

	// Address split
	assign addr_offset = req_addr[BYTE_BITS +: OFFSET_BITS];
	assign addr_index  = req_addr[BYTE_BITS + OFFSET_BITS +: INDEX_BITS];
	assign addr_tag    = req_addr[ADDR_BITS-1 -: TAG_BITS];

	// ------------------------------------------------------------------------
	// Lookup
	// ------------------------------------------------------------------------

	assign hit        = valid[addr_index] && (tags[addr_index] == addr_tag);
	assign store_word = lines[addr_index].words[addr_offset];

	// ------------------------------------------------------------------------
	// Update
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
		end else if (fill_en) begin
			valid[addr_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			lines[addr_index].flat <= memresp_data.flat;
			tags[addr_index]       <= addr_tag;
		end else if (word_wr_en) begin
			// Write hit, memory gets the same word through the write path
			lines[addr_index].words[addr_offset] <= req_data;
		end
	end

endmodule

/* design/sec_cache_top.sv */
/*
 * Secure blocking cache top. Ties the controller, datapath and line store
 * to the processor port and the line-wide memory port.
 */

`timescale 1ns/10ps

module sec_cache_top (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                high_only,

	// Processor request
	input  logic                                procreq_val,
	output logic                                procreq_rdy,
	input  logic                                procreq_type,
	input  logic [sec_cache_pkg::ADDR_BITS-1:0] procreq_addr,
	input  logic [sec_cache_pkg::WORD_BITS-1:0] procreq_data,
	input  logic                                procreq_domain,

	// Processor response
	output logic                                procresp_val,
	input  logic                                procresp_rdy,
	output logic [sec_cache_pkg::WORD_BITS-1:0] procresp_data,

	// Memory request
	output logic                                memreq_val,
	input  logic                                memreq_rdy,
	output logic                                memreq_type,
	output logic [sec_cache_pkg::ADDR_BITS-1:0] memreq_addr,
	output logic [sec_cache_pkg::WORD_BITS-1:0] memreq_data,

	// Memory response
	input  logic                                memresp_val,
	output logic                                memresp_rdy,
	input  sec_cache_pkg::line_u                memresp_data
);

	import sec_cache_pkg::*;

	logic req_load;
	logic resp_load;
	logic resp_sel;
	logic fill_en;
	logic word_wr_en;
	logic cacheable;
	logic is_write;
	logic hit;

	logic [WORD_BITS-1:0] store_word;

	sec_cache_ctrl ctrl_i (
		.clk          (clk),
		.reset        (reset),
		.procreq_val  (procreq_val),
		.procreq_rdy  (procreq_rdy),
		.procresp_val (procresp_val),
		.procresp_rdy (procresp_rdy),
		.memreq_val   (memreq_val),
		.memreq_type  (memreq_type),
		.memreq_rdy   (memreq_rdy),
		.memresp_val  (memresp_val),
		.memresp_rdy  (memresp_rdy),
		.cacheable    (cacheable),
		.is_write     (is_write),
		.hit          (hit),
		.req_load     (req_load),
		.resp_load    (resp_load),
		.resp_sel     (resp_sel),
		.fill_en      (fill_en),
		.word_wr_en   (word_wr_en)
	);

	// Registered address and data feed both the store and the memory port
	sec_cache_datapath datapath_i (
		.clk            (clk),
		.req_load       (req_load),
		.resp_load      (resp_load),
		.resp_sel       (resp_sel),
		.high_only      (high_only),
		.procreq_type   (procreq_type),
		.procreq_addr   (procreq_addr),
		.procreq_data   (procreq_data),
		.procreq_domain (procreq_domain),
		.store_word     (store_word),
		.memresp_data   (memresp_data),
		.is_write       (is_write),
		.cacheable      (cacheable),
		.req_addr       (memreq_addr),
		.req_data       (memreq_data),
		.procresp_data  (procresp_data)
	);

	sec_cache_store store_i (
		.clk          (clk),
		.reset        (reset),
		.req_addr     (memreq_addr),
		.req_data     (memreq_data),
		.fill_en      (fill_en),
		.word_wr_en   (word_wr_en),
		.memresp_data (memresp_data),
		.hit          (hit),
		.store_word   (store_word)
	);

endmodule

/* test/tb_sec_cache_tasks.svh */
/*
 * Request driver, compare tasks and directed tests for the secure cache.
 * Included inside the testbench module after the package import.
 */

// Reference copy of the words written by the tests
logic [WORD_BITS-1:0] ref_store [logic [29:0]];

function automatic logic [WORD_BITS-1:0] expected_word(input logic [ADDR_BITS-1:0] addr);
	if (ref_store.exists(addr[31:2]))
		return ref_store[addr[31:2]];
	return {2'b00, addr[31:2]} ^ 32'h5a5a_0000;
endfunction

// ----------------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------------

task automatic compare_word(input string what, input logic [WORD_BITS-1:0] got,
	input logic [WORD_BITS-1:0] exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		error_count++;
	end
endtask

task automatic compare_addr(input string what, input logic [ADDR_BITS-1:0] got,
	input logic [ADDR_BITS-1:0] exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		error_count++;
	end
endtask

task automatic compare_flag(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
		error_count++;
	end
endtask

task automatic compare_count(input string what, input int got, input int exp);
	if (got != exp) begin
		$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		error_count++;
	end
endtask

task automatic finish_test(input string name, input int err_start);
	if (error_count == err_start) begin
		pass_count++;
		$display("Test %s: ok", name);
	end else begin
		fail_count++;
		$display("Test %s: failed with %0d errors", name, error_count - err_start);
	end
endtask

// ----------------------------------------------------------------------------
// Driver
// ----------------------------------------------------------------------------

task automatic set_policy(input logic value);
	@(posedge clk);
	#2;
	high_only = value;
	@(negedge clk);
endtask

// Latency counts clock edges from acceptance to the first one with procresp_val
task automatic do_request(input logic rtype, input logic [ADDR_BITS-1:0] addr,
	input logic [WORD_BITS-1:0] wdata, input logic domain, input logic stall,
	output logic [WORD_BITS-1:0] rdata, output int latency);
	int                   span;
	logic [WORD_BITS-1:0] first_data;
	@(posedge clk);
	#2;
	procreq_val    = 1'b1;
	procreq_type   = rtype;
	procreq_addr   = addr;
	procreq_data   = wdata;
	procreq_domain = domain;
	procresp_rdy   = !stall;
	do begin
		@(negedge clk);
	end while (!procreq_rdy);
	@(posedge clk);
	#2;
	procreq_val = 1'b0;
	latency = 0;
	do begin
		@(negedge clk);
		latency++;
	end while (!procresp_val);
	first_data = procresp_data;
	if (stall) begin
		span = $unsigned($random(seed)) % 4;
		repeat (span + 1) @(posedge clk);
		#2;
		procresp_rdy = 1'b1;
		@(negedge clk);
		compare_flag("procresp_val under stall", procresp_val, 1'b1);
		compare_word("procresp_data under stall", procresp_data, first_data);
	end
	rdata = procresp_data;
	@(posedge clk);
	#2;
	procresp_rdy = 1'b0;
	@(negedge clk);
endtask

// One non-stalled read checked for data and memory traffic
task automatic check_read(input string what, input logic [ADDR_BITS-1:0] addr,
	input logic domain, input int mem_reqs, output int latency);
	int                   count_start;
	logic [WORD_BITS-1:0] rdata;
	count_start = mem_req_count;
	do_request(REQ_READ, addr, '0, domain, 1'b0, rdata, latency);
	compare_count({what, " memory requests"}, mem_req_count - count_start, mem_reqs);
	compare_word({what, " data"}, rdata, expected_word(addr));
endtask

task automatic check_write(input logic [ADDR_BITS-1:0] addr,
	input logic [WORD_BITS-1:0] wdata);
	int                   count_start;
	int                   latency;
	logic [WORD_BITS-1:0] rdata;
	count_start = mem_req_count;
	do_request(REQ_WRITE, addr, wdata, DOMAIN_HIGH, 1'b0, rdata, latency);
	ref_store[addr[31:2]] = wdata;
	compare_count("write memory requests", mem_req_count - count_start, 1);
	compare_flag("write memreq_type", last_mem_type, REQ_WRITE);
	compare_word("memory after write", mem_read(addr), wdata);
endtask

// ----------------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------------

task automatic test_reset_state();
	int err_start;
	int latency;
	err_start = error_count;
	@(negedge clk);
	compare_flag("procreq_rdy after reset", procreq_rdy, 1'b1);
	compare_flag("procresp_val after reset", procresp_val, 1'b0);
	compare_flag("memreq_val after reset", memreq_val, 1'b0);
	compare_flag("memresp_rdy after reset", memresp_rdy, 1'b0);
	check_read("first read", 32'h0000_0100, DOMAIN_HIGH, 1, latency);
	finish_test("reset state", err_start);
endtask

task automatic test_miss_then_hit();
	int err_start;
	int latency;
	err_start = error_count;
	set_policy(1'b1);
	check_read("high miss", 32'h0000_0204, DOMAIN_HIGH, 1, latency);
	compare_flag("refill memreq_type", last_mem_type, REQ_READ);
	check_read("high hit", 32'h0000_0208, DOMAIN_HIGH, 0, latency);
	compare_count("hit latency", latency, 3);
	finish_test("miss then hit", err_start);
endtask

task automatic test_low_bypass();
	int err_start;
	int latency;
	err_start = error_count;
	set_policy(1'b1);
	check_read("low bypass 1", 32'h0000_0300, DOMAIN_LOW, 1, latency);
	check_read("low bypass 2", 32'h0000_0300, DOMAIN_LOW, 1, latency);
	finish_test("low bypass", err_start);
endtask

task automatic test_policy_off();
	int err_start;
	int latency;
	err_start = error_count;
	set_policy(1'b0);
	check_read("low miss", 32'h0000_040c, DOMAIN_LOW, 1, latency);
	check_read("low hit", 32'h0000_0400, DOMAIN_LOW, 0, latency);
	set_policy(1'b1);
	finish_test("policy off", err_start);
endtask

task automatic test_write_through();
	int err_start;
	int latency;
	err_start = error_count;
	set_policy(1'b1);
	check_read("line fill", 32'h0000_0500, DOMAIN_HIGH, 1, latency);
	check_write(32'h0000_0504, 32'hdead_beef);
	check_read("read after write hit", 32'h0000_0504, DOMAIN_HIGH, 0, latency);
	// No allocate, so the written line stays out of the store
	check_write(32'h0000_0614, 32'h1234_5678);
	check_read("read after write miss", 32'h0000_0614, DOMAIN_HIGH, 1, latency);
	finish_test("write-through", err_start);
endtask

task automatic test_back_pressure();
	int                   err_start;
	int                   latency;
	logic [ADDR_BITS-1:0] addr;
	logic                 wr;
	logic                 domain;
	logic [WORD_BITS-1:0] wdata;
	logic [WORD_BITS-1:0] rdata;
	err_start = error_count;
	set_policy(1'b1);
	for (int i = 0; i < 20; i++) begin
		addr  = $random(seed) & 32'h0000_07fc;
		wr    = ($random(seed) & 3) == 0;
		wdata = $random(seed);
		// Low writes would bypass a cached line, so writes stay high
		domain = wr ? DOMAIN_HIGH : 1'($random(seed));
		if (wr) begin
			do_request(REQ_WRITE, addr, wdata, domain, 1'b1, rdata, latency);
			ref_store[addr[31:2]] = wdata;
			compare_word("stalled write memory", mem_read(addr), wdata);
		end else begin
			do_request(REQ_READ, addr, '0, domain, 1'b1, rdata, latency);
			compare_word("stalled read data", rdata, expected_word(addr));
		end
	end
	finish_test("back-pressure", err_start);
endtask

/* test/tb_sec_cache.sv */
/*
 * Testbench for the secure cache. Provides clock, reset, a line-wide memory
 * model with random stalls, a memory request watch, a watchdog and the test run.
 */

`timescale 1ns/10ps

module tb_sec_cache;

	import sec_cache_pkg::*;

	localparam int CLK_PERIOD      = 20;
	localparam int NUM_REQUESTS    = 32;
	localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 40 + 200;

	logic clk;
	logic reset;
	logic high_only;

	logic                 procreq_val;
	logic                 procreq_rdy;
	logic                 procreq_type;
	logic [ADDR_BITS-1:0] procreq_addr;
	logic [WORD_BITS-1:0] procreq_data;
	logic                 procreq_domain;
	logic                 procresp_val;
	logic                 procresp_rdy;
	logic [WORD_BITS-1:0] procresp_data;

	logic                 memreq_val;
	logic                 memreq_rdy;
	logic                 memreq_type;
	logic [ADDR_BITS-1:0] memreq_addr;
	logic [WORD_BITS-1:0] memreq_data;
	logic                 memresp_val;
	logic                 memresp_rdy;
	line_u                memresp_data;

	integer seed;
	int     error_count;
	int     pass_count;
	int     fail_count;

	// Memory words that differ from the fill pattern, by word address
	logic [WORD_BITS-1:0] mem_store [logic [29:0]];
	int                   mem_req_count;
	logic                 last_mem_type;

	// Memory request hold watch
	logic                 hold_check;
	logic [ADDR_BITS-1:0] held_addr;
	logic [WORD_BITS-1:0] held_data;
	logic                 held_type;

	sec_cache_top dut_i (
		.clk            (clk),
		.reset          (reset),
		.high_only      (high_only),
		.procreq_val    (procreq_val),
		.procreq_rdy    (procreq_rdy),
		.procreq_type   (procreq_type),
		.procreq_addr   (procreq_addr),
		.procreq_data   (procreq_data),
		.procreq_domain (procreq_domain),
		.procresp_val   (procresp_val),
		.procresp_rdy   (procresp_rdy),
		.procresp_data  (procresp_data),
		.memreq_val     (memreq_val),
		.memreq_rdy     (memreq_rdy),
		.memreq_type    (memreq_type),
		.memreq_addr    (memreq_addr),
		.memreq_data    (memreq_data),
		.memresp_val    (memresp_val),
		.memresp_rdy    (memresp_rdy),
		.memresp_data   (memresp_data)
	);

	`include "tb_sec_cache_tasks.svh"

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [WORD_BITS-1:0] mem_read(input logic [ADDR_BITS-1:0] addr);
		if (mem_store.exists(addr[31:2]))
			return mem_store[addr[31:2]];
		return {2'b00, addr[31:2]} ^ 32'h5a5a_0000;
	endfunction

	// ------------------------------------------------------------------------
	// Memory model that answers every request with the addressed line
	// ------------------------------------------------------------------------

	initial begin : memory_model
		logic [ADDR_BITS-1:0] addr;
		logic [ADDR_BITS-1:0] base;
		int                   delay;
		memreq_rdy    = 1'b0;
		memresp_val   = 1'b0;
		memresp_data  = '0;
		mem_req_count = 0;
		forever begin
			@(negedge clk);
			if (memreq_val && memreq_rdy) begin
				addr          = memreq_addr;
				last_mem_type = memreq_type;
				if (memreq_type == REQ_WRITE)
					mem_store[addr[31:2]] = memreq_data;
				@(posedge clk);
				mem_req_count++;
				#2;
				memreq_rdy = 1'b0;
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) begin
					@(posedge clk);
					#2;
				end
				base = {addr[31:4], 4'h0};
				for (int i = 0; i < LINE_WORDS; i++)
					memresp_data.words[i] = mem_read(base + 4 * i);
				memresp_val = 1'b1;
				do begin
					@(negedge clk);
				end while (!memresp_rdy);
				@(posedge clk);
				#2;
				memresp_val = 1'b0;
			end else begin
				@(posedge clk);
				#2;
				memreq_rdy = 1'($random(seed));
			end
		end
	end

	// A stalled memory request must not change before it is taken
	always @(negedge clk) begin
		if (hold_check) begin
			compare_flag("memreq_val held", memreq_val, 1'b1);
			compare_flag("memreq_type held", memreq_type, held_type);
			compare_addr("memreq_addr held", memreq_addr, held_addr);
			compare_word("memreq_data held", memreq_data, held_data);
		end
		hold_check = memreq_val && !memreq_rdy && !reset;
		held_addr  = memreq_addr;
		held_data  = memreq_data;
		held_type  = memreq_type;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d clock cycles",
			WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Test run
	// ------------------------------------------------------------------------

	initial begin : test_run
		seed           = 32'h8fc5_7df4;
		error_count    = 0;
		pass_count     = 0;
		fail_count     = 0;
		hold_check     = 1'b0;
		reset          = 1'b1;
		high_only      = 1'b1;
		procreq_val    = 1'b0;
		procreq_type   = REQ_READ;
		procreq_addr   = '0;
		procreq_data   = '0;
		procreq_domain = DOMAIN_LOW;
		procresp_rdy   = 1'b0;

		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		test_reset_state();
		test_miss_then_hit();
		test_low_bypass();
		test_policy_off();
		test_write_through();
		test_back_pressure();

		$display("Tests passed: %0d, failed: %0d, check errors: %0d",
			pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+test
design/sec_cache_pkg.sv
design/sec_cache_ctrl.sv
design/sec_cache_datapath.sv
design/sec_cache_store.sv
design/sec_cache_top.sv
test/tb_sec_cache.sv
